/* rtl/ecc_pkg.sv */
package ecc_pkg;

    localparam int COORD_W   = 32;
    localparam int KEY_BITS  = 32;               // includes the implicit top bit
    localparam int STEP_W    = 4;
    localparam int KEY_CNT_W = $clog2(KEY_BITS);

    localparam int DBL_STEPS = 12;               // field ops per doubling
    localparam int ADD_STEPS = 9;                // field ops per addition

    typedef logic [COORD_W-1:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } ec_point_t;

    // encoding of the field unit's op select
    typedef enum logic [1:0] {
        FOP_ADD = 2'b00,
        FOP_SUB = 2'b01,
        FOP_MUL = 2'b10,
        FOP_DIV = 2'b11                          // opa / opb
    } field_op_e;

    typedef struct packed {
        field_op_e op;
        coord_t    opa;
        coord_t    opb;
    } fa_req_t;

    typedef enum logic {
        CMD_DOUBLE,
        CMD_ADD
    } point_cmd_e;

    typedef enum logic [2:0] {
        SRC_X1,                                  // accumulator
        SRC_Y1,
        SRC_X2,                                  // base point
        SRC_Y2,
        SRC_R1,
        SRC_R2,
        SRC_A                                    // curve parameter
    } operand_sel_e;

    typedef enum logic [1:0] {
        DST_R1,
        DST_R2,
        DST_X3,                                  // r2 and x3
        DST_Y3                                   // r2 and y3 on the closing step
    } dest_sel_e;

    typedef struct packed {
        field_op_e    op;
        operand_sel_e src_a;
        operand_sel_e src_b;
        dest_sel_e    dest;
    } micro_op_t;

endpackage

/* rtl/point_op_rom.sv */
`timescale 1ns/1ns

module point_op_rom (
    input  ecc_pkg::point_cmd_e            i_cmd,
    input  logic [ecc_pkg::STEP_W-1:0]     i_step,
    output ecc_pkg::micro_op_t             o_uop,
    output logic                           o_last
);
    import ecc_pkg::*;

    function automatic micro_op_t uop(field_op_e op, operand_sel_e sa, operand_sel_e sb,
                                      dest_sel_e d);
        micro_op_t u;
        u.op    = op;
        u.src_a = sa;
        u.src_b = sb;
        u.dest  = d;
        return u;
    endfunction

    always_comb
    begin
        o_uop = uop(FOP_ADD, SRC_X1, SRC_X1, DST_R1);   // steps past the end
        if (i_cmd == CMD_DOUBLE)
        begin
            case (i_step)
                4'd0:
                    o_uop = uop(FOP_MUL, SRC_X1, SRC_X1, DST_R1);   // x1^2
                4'd1:
                    o_uop = uop(FOP_ADD, SRC_R1, SRC_R1, DST_R2);
                4'd2:
                    o_uop = uop(FOP_ADD, SRC_R1, SRC_R2, DST_R1);   // 3 x1^2
                4'd3:
                    o_uop = uop(FOP_ADD, SRC_R1, SRC_A,  DST_R1);
                4'd4:
                    o_uop = uop(FOP_ADD, SRC_Y1, SRC_Y1, DST_R2);   // 2 y1
                4'd5:
                    o_uop = uop(FOP_DIV, SRC_R1, SRC_R2, DST_R1);   // slope
                4'd6:
                    o_uop = uop(FOP_MUL, SRC_R1, SRC_R1, DST_R2);
                4'd7:
                    o_uop = uop(FOP_SUB, SRC_R2, SRC_X1, DST_R2);
                4'd8:
                    o_uop = uop(FOP_SUB, SRC_R2, SRC_X1, DST_X3);
                4'd9:
                    o_uop = uop(FOP_SUB, SRC_X1, SRC_R2, DST_R2);
                4'd10:
                    o_uop = uop(FOP_MUL, SRC_R1, SRC_R2, DST_R1);
                4'd11:
                    o_uop = uop(FOP_SUB, SRC_R1, SRC_Y1, DST_Y3);
                default:
                begin
                end
            endcase
        end
        else
        begin
            case (i_step)
                4'd0:
                    o_uop = uop(FOP_SUB, SRC_X2, SRC_X1, DST_R1);
                4'd1:
                    o_uop = uop(FOP_SUB, SRC_Y2, SRC_Y1, DST_R2);
                4'd2:
                    o_uop = uop(FOP_DIV, SRC_R2, SRC_R1, DST_R1);   // slope
                4'd3:
                    o_uop = uop(FOP_MUL, SRC_R1, SRC_R1, DST_R2);
                4'd4:
                    o_uop = uop(FOP_SUB, SRC_R2, SRC_X1, DST_R2);
                4'd5:
                    o_uop = uop(FOP_SUB, SRC_R2, SRC_X2, DST_X3);
                4'd6:
                    o_uop = uop(FOP_SUB, SRC_X1, SRC_R2, DST_R2);
                4'd7:
                    o_uop = uop(FOP_MUL, SRC_R1, SRC_R2, DST_R2);
                4'd8:
                    o_uop = uop(FOP_SUB, SRC_R2, SRC_Y1, DST_Y3);
                default:
                begin
                end
            endcase
        end
    end

    assign o_last = (i_cmd == CMD_DOUBLE) ? (i_step == STEP_W'(DBL_STEPS - 1))
                                          : (i_step == STEP_W'(ADD_STEPS - 1));

endmodule

/* rtl/point_op_sequencer.sv */
`timescale 1ns/1ns

module point_op_sequencer (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_load,
    input  ecc_pkg::ec_point_t    i_point,
    input  ecc_pkg::coord_t       i_curve_a,
    input  logic                  i_cmd_valid,
    input  ecc_pkg::point_cmd_e   i_cmd,
    input  logic                  i_fa_done,
    input  ecc_pkg::coord_t       i_fa_result,
    output logic                  o_fa_valid,
    output ecc_pkg::fa_req_t      o_fa_req,
    output logic                  o_op_done,
    output ecc_pkg::ec_point_t    o_acc
);
    import ecc_pkg::*;

    ec_point_t           acc;       // x1, y1
    ec_point_t           base;      // x2, y2
    coord_t              a;
    coord_t              r1;
    coord_t              r2;
    coord_t              x3;
    point_cmd_e          cmd;
    logic [STEP_W-1:0]   step;
    logic                run;
    micro_op_t           uop;
    logic                last;
    logic                accept;

    function automatic coord_t pick(operand_sel_e sel, ec_point_t p1, ec_point_t p2,
                                    coord_t ca, coord_t t1, coord_t t2);
        coord_t v;
        case (sel)
            SRC_X1:  v = p1.x;
            SRC_Y1:  v = p1.y;
            SRC_X2:  v = p2.x;
            SRC_Y2:  v = p2.y;
            SRC_R1:  v = t1;
            SRC_R2:  v = t2;
            default: v = ca;
        endcase
        return v;
    endfunction

    point_op_rom u_rom (
        .i_cmd  (cmd),
        .i_step (step),
        .o_uop  (uop),
        .o_last (last)
    );

    assign accept = o_fa_valid && i_fa_done;   // stray done pulses ignored
    assign o_acc  = acc;

    always_comb
    begin
        o_fa_req.op  = uop.op;
        o_fa_req.opa = pick(uop.src_a, acc, base, a, r1, r2);
        o_fa_req.opb = pick(uop.src_b, acc, base, a, r1, r2);
    end

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            run        <= 1'b0;
            o_fa_valid <= 1'b0;
            o_op_done  <= 1'b0;
            step       <= '0;
            cmd        <= CMD_DOUBLE;
        end
        else
        begin
            o_op_done <= 1'b0;
            if (i_cmd_valid && !run)
            begin
                run        <= 1'b1;
                o_fa_valid <= 1'b1;
                step       <= '0;
                cmd        <= i_cmd;
            end
            else if (accept)
            begin
                o_fa_valid <= 1'b0;         // one idle cycle between requests
                step       <= step + 1'b1;
                if (last)
                begin
                    run       <= 1'b0;
                    o_op_done <= 1'b1;
                end
            end
            else if (run && !o_fa_valid)
            begin
                o_fa_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_load)
        begin
            acc  <= i_point;
            base <= i_point;
            a    <= i_curve_a;
        end
        else if (accept)
        begin
            case (uop.dest)
                DST_R1:
                    r1 <= i_fa_result;
                DST_R2:
                    r2 <= i_fa_result;
                DST_X3:
                begin
                    r2 <= i_fa_result;
                    x3 <= i_fa_result;
                end
                default:
                begin
                    r2  <= i_fa_result;
                    acc <= '{x: x3, y: i_fa_result};   // new accumulator
                end
            endcase
        end
    end

endmodule

/* rtl/scalar_bit_scheduler.sv */
`timescale 1ns/1ns

module scalar_bit_scheduler (
    input  logic                          i_clk,
    input  logic                          i_reset,
    input  logic                          i_start,
    input  logic [ecc_pkg::KEY_BITS-1:0]  i_key,
    input  logic                          i_op_done,
    output logic                          o_load,
    output logic                          o_cmd_valid,
    output ecc_pkg::point_cmd_e           o_cmd,
    output logic                          o_busy,
    output logic                          o_done
);
    import ecc_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOAD,
        S_DBL,
        S_ADD
    } sched_state_e;

    sched_state_e           state;
    logic [KEY_BITS-2:0]    key_sr;     // key below the implicit top bit
    logic [KEY_CNT_W-1:0]   bit_cnt;
    logic                   cur_bit;
    logic                   take_start;
    logic                   bit_end;
    logic                   last_bit;

    assign cur_bit    = key_sr[KEY_BITS-2];
    assign take_start = (state == S_IDLE) && i_start;
    assign bit_end    = i_op_done && ((state == S_ADD) || ((state == S_DBL) && !cur_bit));
    assign last_bit   = (bit_cnt == KEY_CNT_W'(KEY_BITS - 2));

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            state       <= S_IDLE;
            bit_cnt     <= '0;
            o_load      <= 1'b0;
            o_cmd_valid <= 1'b0;
            o_cmd       <= CMD_DOUBLE;
            o_busy      <= 1'b0;
            o_done      <= 1'b0;
        end
        else
        begin
            o_load      <= 1'b0;
            o_cmd_valid <= 1'b0;
            o_done      <= 1'b0;
            if (take_start)
            begin
                o_busy  <= 1'b1;
                o_load  <= 1'b1;
                bit_cnt <= '0;
                state   <= S_LOAD;
            end
            else if (state == S_LOAD)
            begin
                o_cmd_valid <= 1'b1;            // first doubling
                o_cmd       <= CMD_DOUBLE;
                state       <= S_DBL;
            end
            else if ((state == S_DBL) && i_op_done && cur_bit)
            begin
                o_cmd_valid <= 1'b1;
                o_cmd       <= CMD_ADD;
                state       <= S_ADD;
            end
            else if (bit_end && last_bit)
            begin
                o_busy <= 1'b0;
                o_done <= 1'b1;
                state  <= S_IDLE;
            end
            else if (bit_end)
            begin
                bit_cnt     <= bit_cnt + 1'b1;
                o_cmd_valid <= 1'b1;
                o_cmd       <= CMD_DOUBLE;
                state       <= S_DBL;
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (take_start)
        begin
            key_sr <= i_key[KEY_BITS-2:0];
        end
        else if (bit_end && !last_bit)
        begin
            key_sr <= {key_sr[KEY_BITS-3:0], 1'b0};   // next bit to the top
        end
    end

endmodule

/* rtl/ecc_scalar_mult.sv */
`timescale 1ns/1ns

module ecc_scalar_mult (
    input  logic                          i_clk,
    input  logic                          i_reset,
    input  logic                          i_start,
    input  ecc_pkg::ec_point_t            i_point,
    input  ecc_pkg::coord_t               i_curve_a,
    input  logic [ecc_pkg::KEY_BITS-1:0]  i_key,
    input  logic                          i_fa_done,
    input  ecc_pkg::coord_t               i_fa_result,
    output logic                          o_busy,
    output logic                          o_done,
    output ecc_pkg::ec_point_t            o_result,
    output logic                          o_fa_valid,
    output ecc_pkg::fa_req_t              o_fa_req
);
    import ecc_pkg::*;

    logic        load;
    logic        cmd_valid;
    point_cmd_e  cmd;
    logic        op_done;

    scalar_bit_scheduler u_sched (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_start     (i_start),
        .i_key       (i_key),
        .i_op_done   (op_done),
        .o_load      (load),
        .o_cmd_valid (cmd_valid),
        .o_cmd       (cmd),
        .o_busy      (o_busy),
        .o_done      (o_done)
    );

    point_op_sequencer u_seq (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_load      (load),
        .i_point     (i_point),
        .i_curve_a   (i_curve_a),
        .i_cmd_valid (cmd_valid),
        .i_cmd       (cmd),
        .i_fa_done   (i_fa_done),
        .i_fa_result (i_fa_result),
        .o_fa_valid  (o_fa_valid),
        .o_fa_req    (o_fa_req),
        .o_op_done   (op_done),
        .o_acc       (o_result)      // held until the next load
    );

endmodule

/* test/ecc_scalar_mult_properties.sv */
`timescale 1ns/1ns

module ecc_scalar_mult_properties (
    input logic             i_clk,
    input logic             i_reset,
    input logic             i_fa_done,
    input logic             o_busy,
    input logic             o_done,
    input logic             o_fa_valid,
    input ecc_pkg::fa_req_t o_fa_req
);

    done_single: assert property (@(posedge i_clk) disable iff (i_reset)
        o_done |=> !o_done)
        else $error("o_done high for more than one cycle");

    valid_busy: assert property (@(posedge i_clk) disable iff (i_reset)
        o_fa_valid |-> o_busy)
        else $error("o_fa_valid high while o_busy is low");

    // request held until the field unit answers
    req_stable: assert property (@(posedge i_clk) disable iff (i_reset)
        o_fa_valid && !i_fa_done |=> $stable(o_fa_req))
        else $error("o_fa_req changed while a request was outstanding");

    req_gap: assert property (@(posedge i_clk) disable iff (i_reset)
        o_fa_valid && i_fa_done |=> !o_fa_valid)
        else $error("o_fa_valid not dropped after an accepted i_fa_done");

endmodule

bind ecc_scalar_mult ecc_scalar_mult_properties u_props (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_fa_done  (i_fa_done),
    .o_busy     (o_busy),
    .o_done     (o_done),
    .o_fa_valid (o_fa_valid),
    .o_fa_req   (o_fa_req)
);

/* test/tb_ecc_scalar_mult.sv */
`timescale 1ns/1ns

module tb_ecc_scalar_mult;
    import ecc_pkg::*;

    localparam int unsigned PRIME = 65521;
    localparam int N_RUNS      = 11;
    localparam int RUN_CYCLES  = KEY_BITS * 21 * 10;
    localparam int WATCHDOG_NS = N_RUNS * KEY_BITS * 21 * 8 * 4 + 100000;

    logic                i_clk = 1'b0;
    logic                i_reset;
    logic                i_start;
    ec_point_t           i_point;
    coord_t              i_curve_a;
    logic [KEY_BITS-1:0] i_key;
    logic                i_fa_done = 1'b0;
    coord_t              i_fa_result = '0;
    logic                o_busy;
    logic                o_done;
    ec_point_t           o_result;
    logic                o_fa_valid;
    fa_req_t             o_fa_req;
    int                  req_count = 0;
    int                  fa_left = 0;
    bit                  fa_wait = 1'b0;
    bit                  fixed_lat = 1'b0;   // one-cycle field unit
    int                  errors = 0;
    int                  checks = 0;

    ecc_scalar_mult dut0 (.*);

    initial
    begin
        forever #2 i_clk = ~i_clk;
    end

    // arithmetic mod PRIME with division through the Fermat inverse
    function automatic coord_t fop(field_op_e op, coord_t a, coord_t b);
        longint unsigned x, y, r, e;
        x = 64'(a) % PRIME;
        y = 64'(b) % PRIME;
        if (op == FOP_DIV)
        begin
            r = 1;
            for (e = PRIME - 2; e != 0; e = e >> 1)
            begin
                if (e[0])
                    r = r * y % PRIME;
                y = y * y % PRIME;
            end
            y = r;
        end
        case (op)
            FOP_ADD: r = (x + y) % PRIME;
            FOP_SUB: r = (x + PRIME - y) % PRIME;
            default: r = x * y % PRIME;
        endcase
        return coord_t'(r);
    endfunction

    function automatic ec_point_t ref_point_op(ec_point_t q, ec_point_t p, coord_t ca, bit dbl,
                                               inout bit zero_den);
        coord_t    num, den, lam;
        ec_point_t r;
        if (dbl)
        begin
            num = fop(FOP_ADD, fop(FOP_MUL, 3, fop(FOP_MUL, q.x, q.x)), ca);
            den = fop(FOP_ADD, q.y, q.y);
            p   = q;                           // tangent uses q as the second point
        end
        else
        begin
            num = fop(FOP_SUB, p.y, q.y);
            den = fop(FOP_SUB, p.x, q.x);
        end
        zero_den |= (den == 0);
        lam = fop(FOP_DIV, num, den);
        r.x = fop(FOP_SUB, fop(FOP_MUL, lam, lam), fop(FOP_ADD, q.x, p.x));
        r.y = fop(FOP_SUB, fop(FOP_MUL, lam, fop(FOP_SUB, q.x, r.x)), q.y);
        return r;
    endfunction

    function automatic ec_point_t ref_mult(ec_point_t p, coord_t ca, logic [KEY_BITS-1:0] k,
                                           output bit zero_den);
        ec_point_t q;
        q        = p;                          // top key bit taken as 1
        zero_den = 1'b0;
        for (int i = KEY_BITS - 2; i >= 0; i--)
        begin
            q = ref_point_op(q, p, ca, 1'b1, zero_den);
            if (k[i])
                q = ref_point_op(q, p, ca, 1'b0, zero_den);
        end
        return q;
    endfunction

    // field unit model handling one request at a time
    always @(posedge i_clk)
    begin
        if (i_reset)
        begin
            i_fa_done <= 1'b0;
            fa_wait   <= 1'b0;
        end
        else
        begin
            i_fa_done <= 1'b0;
            if (fa_wait && fa_left <= 1)
            begin
                i_fa_done   <= 1'b1;
                i_fa_result <= fop(o_fa_req.op, o_fa_req.opa, o_fa_req.opb);
                fa_wait     <= 1'b0;
            end
            else if (fa_wait)
                fa_left <= fa_left - 1;
            else if (o_fa_valid && !i_fa_done)
            begin
                fa_wait   <= 1'b1;
                fa_left   <= fixed_lat ? 1 : $urandom_range(6, 1);
                req_count <= req_count + 1;
            end
        end
    end

    task automatic check_hex(string name, logic [63:0] got, logic [63:0] want);
        checks++;
        assert (got == want)
        else
        begin
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, want);
            errors++;
        end
    endtask

    task automatic draw_case(bit dbl_only, output ec_point_t p, output coord_t ca,
                             output logic [KEY_BITS-1:0] k);
        bit zero_den;
        zero_den = 1'b1;
        while (zero_den)                       // redraw on a zero denominator
        begin
            p.x = $urandom_range(PRIME - 1, 1);
            p.y = $urandom_range(PRIME - 1, 1);
            ca  = $urandom_range(PRIME - 1, 0);
            k   = dbl_only ? {1'b1, {(KEY_BITS-1){1'b0}}} : KEY_BITS'($urandom());
            void'(ref_mult(p, ca, k, zero_den));
        end
    endtask

    task automatic run_mult(ec_point_t p, coord_t ca, logic [KEY_BITS-1:0] k, bit poke,
                            output ec_point_t res);
        ec_point_t want;
        bit        zero_den;
        int        reqs;
        int        n;
        want = ref_mult(p, ca, k, zero_den);
        reqs = req_count;
        n    = 0;
        @(posedge i_clk);
        i_point   <= p;
        i_curve_a <= ca;
        i_key     <= k;
        i_start   <= 1'b1;
        @(posedge i_clk);
        i_start <= 1'b0;
        while (!o_done && n < RUN_CYCLES)
        begin
            @(posedge i_clk);
            n++;
            if (poke && n == 200)
            begin
                check_hex("o_busy", o_busy, 1);
                i_key   <= ~k;                 // start while busy with another key
                i_start <= 1'b1;
            end
            else
                i_start <= 1'b0;
        end
        assert (o_done)
        else
        begin
            $display("no o_done within %0d cycles of the start", RUN_CYCLES);
            errors++;
        end
        res = o_result;
        check_hex("o_busy", o_busy, 0);
        check_hex("o_result", o_result, want);
        check_hex("request count", req_count - reqs,
                  12 * (KEY_BITS - 1) + 9 * $countones(k[KEY_BITS-2:0]));
    endtask

    task automatic idle_after_reset();
        repeat (3)
        begin
            @(posedge i_clk);
            check_hex("o_busy", o_busy, 0);
            check_hex("o_done", o_done, 0);
            check_hex("o_fa_valid", o_fa_valid, 0);
        end
    endtask

    task automatic pure_doubling();
        ec_point_t           p, r;
        coord_t              ca;
        logic [KEY_BITS-1:0] k;
        draw_case(1'b1, p, ca, k);
        run_mult(p, ca, k, 1'b0, r);
    endtask

    task automatic random_key_runs(int count);
        ec_point_t           p, r;
        coord_t              ca;
        logic [KEY_BITS-1:0] k;
        repeat (count)
        begin
            draw_case(1'b0, p, ca, k);         // new point, a and key each run
            run_mult(p, ca, k, 1'b0, r);
        end
    endtask

    task automatic latency_independence();
        ec_point_t           p, r_fixed, r_rand;
        coord_t              ca;
        logic [KEY_BITS-1:0] k;
        draw_case(1'b0, p, ca, k);
        fixed_lat = 1'b1;
        run_mult(p, ca, k, 1'b0, r_fixed);
        fixed_lat = 1'b0;
        run_mult(p, ca, k, 1'b0, r_rand);
        check_hex("o_result latency", r_rand, r_fixed);
    endtask

    task automatic start_while_busy();
        ec_point_t           p, r;
        coord_t              ca;
        logic [KEY_BITS-1:0] k;
        draw_case(1'b0, p, ca, k);
        run_mult(p, ca, k, 1'b1, r);
        repeat (20)
        begin
            @(posedge i_clk);
            check_hex("o_result hold", o_result, r);
        end
    endtask

    initial
    begin
        void'($urandom(32'he9e2));
        i_reset   = 1'b1;
        i_start   = 1'b0;
        i_point   = '0;
        i_curve_a = '0;
        i_key     = '0;
        repeat (5) @(posedge i_clk);
        i_reset <= 1'b0;
        idle_after_reset();
        pure_doubling();
        random_key_runs(4);
        latency_independence();
        start_while_busy();
        random_key_runs(3);                    // back to back
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("Testbench failed");
        $finish;
    end

endmodule

/* vlog.f */
rtl/ecc_pkg.sv
rtl/point_op_rom.sv
rtl/point_op_sequencer.sv
rtl/scalar_bit_scheduler.sv
rtl/ecc_scalar_mult.sv
test/ecc_scalar_mult_properties.sv
test/tb_ecc_scalar_mult.sv
